// ==== rtl/echo_pkg.sv ====
`default_nettype none

package echo_pkg;

    localparam int FLOW_ID_W    = 4;
    localparam int MAX_FLOW_CNT = 16;   // also the flow FIFO depth.

    localparam int PTR_W        = 12;   // byte offset wraps modulo 4096.

    localparam int MAX_CHUNK    = 64;   // largest single copy, in bytes.
    localparam int LEN_W        = 7;

    typedef logic [FLOW_ID_W-1:0] flow_id_t;

    typedef logic [PTR_W-1:0]     rx_ptr_t;

    typedef logic [LEN_W-1:0]     chunk_len_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_LOAD,       // read head and commit for the flow.
        ENG_ISSUE,      // offer the copy request.
        ENG_UPDATE,     // write back the advanced head.
        ENG_REQUEUE
    } engine_state_t;

endpackage

`default_nettype wire

// ==== rtl/echo_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// pointer lookup and head write-back between one engine and the table
interface ptr_access_if import echo_pkg::*; ();

    flow_id_t   flow_id;
    logic       upd_val;
    rx_ptr_t    new_head;
    rx_ptr_t    rx_head;
    rx_ptr_t    rx_commit;

    modport engine (
         output flow_id
        ,output upd_val
        ,output new_head
        ,input  rx_head
        ,input  rx_commit
    );

    modport ptr_table (
         input  flow_id
        ,input  upd_val
        ,input  new_head
        ,output rx_head
        ,output rx_commit
    );

endinterface

interface copy_req_if import echo_pkg::*; ();

    logic       val;
    flow_id_t   flow_id;
    rx_ptr_t    offset;
    chunk_len_t len;
    logic       rdy;

    modport src (
         output val
        ,output flow_id
        ,output offset
        ,output len
        ,input  rdy
    );

    modport sink (
         input  val
        ,input  flow_id
        ,input  offset
        ,input  len
        ,output rdy
    );

endinterface

`default_nettype wire

// ==== rtl/flow_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_sched import echo_pkg::*; #(
    parameter int NUM_ENGINES = 2
) (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       new_flow_val
    ,input  flow_id_t                   new_flow_id

    ,output logic [NUM_ENGINES-1:0]     dispatch_val
    ,output flow_id_t                   dispatch_flow_id
    ,input  logic [NUM_ENGINES-1:0]     idle

    ,input  logic [NUM_ENGINES-1:0]     requeue_val
    ,input  flow_id_t                   requeue_flow_id [NUM_ENGINES]
    ,output logic [NUM_ENGINES-1:0]     requeue_rdy
);
    localparam int FIFO_AW = $clog2(MAX_FLOW_CNT);

    logic               nf_val_q;
    flow_id_t           nf_id_q;

    flow_id_t           fifo_mem [MAX_FLOW_CNT];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;
    logic               fifo_full;
    logic               fifo_empty;

    logic               push;
    logic               pop;
    flow_id_t           push_id;

    assign fifo_full  = (count_q == (FIFO_AW+1)'(MAX_FLOW_CNT));
    assign fifo_empty = (count_q == '0);

    // new flows win, otherwise the lowest requeueing engine.
    always_comb begin
        requeue_rdy = '0;
        push_id     = nf_id_q;
        if (!nf_val_q && !fifo_full) begin
            for (int i = NUM_ENGINES - 1; i >= 0; i--) begin
                if (requeue_val[i]) begin
                    requeue_rdy    = '0;
                    requeue_rdy[i] = 1'b1;
                    push_id        = requeue_flow_id[i];
                end
            end
        end
    end

    assign push = nf_val_q | (|requeue_rdy);

    always_comb begin
        dispatch_val = '0;
        for (int i = NUM_ENGINES - 1; i >= 0; i--) begin
            if (idle[i] && !fifo_empty) begin
                dispatch_val    = '0;
                dispatch_val[i] = 1'b1;   // lowest idle engine ends up last.
            end
        end
    end

    assign pop              = |dispatch_val;
    assign dispatch_flow_id = fifo_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            nf_val_q <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            nf_val_q <= new_flow_val;
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_AW'(MAX_FLOW_CNT - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_AW'(MAX_FLOW_CNT - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        nf_id_q <= new_flow_id;
        if (push) begin
            fifo_mem[wr_ptr_q] <= push_id;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/flow_ptr_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_ptr_table import echo_pkg::*; #(
    parameter int NUM_ENGINES = 2
) (
     input  logic           clk
    ,input  logic           rst

    ,input  logic           commit_val
    ,input  flow_id_t       commit_flow_id
    ,input  rx_ptr_t        commit_ptr

    ,ptr_access_if.ptr_table ptr [NUM_ENGINES]
);
    rx_ptr_t                head_q   [MAX_FLOW_CNT];
    rx_ptr_t                commit_q [MAX_FLOW_CNT];

    logic [NUM_ENGINES-1:0] upd_val;
    flow_id_t               upd_id   [NUM_ENGINES];
    rx_ptr_t                upd_head [NUM_ENGINES];

    generate
        for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_port
            assign ptr[i].rx_head   = head_q[ptr[i].flow_id];
            assign ptr[i].rx_commit = commit_q[ptr[i].flow_id];

            assign upd_val[i]  = ptr[i].upd_val;
            assign upd_id[i]   = ptr[i].flow_id;
            assign upd_head[i] = ptr[i].new_head;
        end
    endgenerate

    // a flow lives in one engine at a time, so head writes never collide.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int f = 0; f < MAX_FLOW_CNT; f++) begin
                head_q[f]   <= '0;
                commit_q[f] <= '0;
            end
        end else begin
            for (int e = 0; e < NUM_ENGINES; e++) begin
                if (upd_val[e]) begin
                    head_q[upd_id[e]] <= upd_head[e];
                end
            end
            if (commit_val) begin
                commit_q[commit_flow_id] <= commit_ptr;   // stands in for the rx engine.
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/echo_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_engine import echo_pkg::*; (
     input  logic           clk
    ,input  logic           rst

    ,input  logic           dispatch_val
    ,input  flow_id_t       dispatch_flow_id
    ,output logic           idle

    ,output logic           requeue_val
    ,output flow_id_t       requeue_flow_id
    ,input  logic           requeue_rdy

    ,ptr_access_if.engine   ptr
    ,copy_req_if.src        copy
);
    engine_state_t  state_q;
    engine_state_t  state_d;

    flow_id_t       flow_q;
    rx_ptr_t        head_q;
    chunk_len_t     len_q;

    rx_ptr_t        avail;
    chunk_len_t     len_calc;

    // bytes waiting modulo the buffer size.
    assign avail    = ptr.rx_commit - ptr.rx_head;
    assign len_calc = (avail > rx_ptr_t'(MAX_CHUNK)) ? chunk_len_t'(MAX_CHUNK)
                                                     : chunk_len_t'(avail);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ENG_IDLE: begin
                if (dispatch_val) begin
                    state_d = ENG_LOAD;
                end
            end
            ENG_LOAD: begin
                state_d = (len_calc != '0) ? ENG_ISSUE : ENG_REQUEUE;
            end
            ENG_ISSUE: begin
                if (copy.rdy) begin
                    state_d = ENG_UPDATE;
                end
            end
            ENG_UPDATE: begin
                state_d = ENG_REQUEUE;
            end
            ENG_REQUEUE: begin
                if (requeue_rdy) begin
                    state_d = ENG_IDLE;
                end
            end
            default: state_d = ENG_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ENG_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ENG_IDLE && dispatch_val) begin
            flow_q <= dispatch_flow_id;
        end
        if (state_q == ENG_LOAD) begin
            head_q <= ptr.rx_head;
            len_q  <= len_calc;
        end
    end

    assign idle            = (state_q == ENG_IDLE);

    assign ptr.flow_id     = flow_q;
    assign ptr.upd_val     = (state_q == ENG_UPDATE);
    assign ptr.new_head    = head_q + rx_ptr_t'(len_q);

    assign copy.val        = (state_q == ENG_ISSUE);   // payload is held in regs.
    assign copy.flow_id    = flow_q;
    assign copy.offset     = head_q;
    assign copy.len        = len_q;

    assign requeue_val     = (state_q == ENG_REQUEUE);
    assign requeue_flow_id = flow_q;

endmodule

`default_nettype wire

// ==== rtl/copy_req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_req_arbiter import echo_pkg::*; #(
    parameter int NUM_ENGINES = 2
) (
     input  logic           clk
    ,input  logic           rst

    ,copy_req_if.sink       req [NUM_ENGINES]

    ,output logic           copy_val
    ,output flow_id_t       copy_flow_id
    ,output rx_ptr_t        copy_offset
    ,output chunk_len_t     copy_len
    ,input  logic           copy_rdy
);
    localparam int IDX_W = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

    logic [NUM_ENGINES-1:0] val_w;
    flow_id_t               fid_w [NUM_ENGINES];
    rx_ptr_t                off_w [NUM_ENGINES];
    chunk_len_t             len_w [NUM_ENGINES];

    logic [IDX_W-1:0]       rr_q;         // first engine to look at.
    logic                   hold_q;       // grant locked while the output waits.
    logic [IDX_W-1:0]       hold_idx_q;
    logic [IDX_W-1:0]       sel_idx;
    logic                   sel_found;
    int unsigned            cand;

    generate
        for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_req
            assign val_w[i]   = req[i].val;
            assign fid_w[i]   = req[i].flow_id;
            assign off_w[i]   = req[i].offset;
            assign len_w[i]   = req[i].len;
            assign req[i].rdy = copy_rdy && (sel_idx == IDX_W'(i));
        end
    endgenerate

    always_comb begin
        sel_idx   = hold_idx_q;
        sel_found = hold_q;
        cand      = 0;
        if (!hold_q) begin
            for (int k = 0; k < NUM_ENGINES; k++) begin
                cand = int'(rr_q) + k;
                if (cand >= NUM_ENGINES) begin
                    cand = cand - NUM_ENGINES;
                end
                if (!sel_found && val_w[cand]) begin
                    sel_found = 1'b1;
                    sel_idx   = IDX_W'(cand);
                end
            end
        end
    end

    assign copy_val     = sel_found && val_w[sel_idx];
    assign copy_flow_id = fid_w[sel_idx];
    assign copy_offset  = off_w[sel_idx];
    assign copy_len     = len_w[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_q       <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else if (copy_val && copy_rdy) begin
            hold_q <= 1'b0;
            rr_q   <= (sel_idx == IDX_W'(NUM_ENGINES - 1)) ? '0 : sel_idx + 1'b1;
        end else if (copy_val) begin
            hold_q     <= 1'b1;
            hold_idx_q <= sel_idx;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_top import echo_pkg::*; #(
    parameter int NUM_ENGINES = 2
) (
     input  logic           clk
    ,input  logic           rst

    ,input  logic           new_flow_val
    ,input  flow_id_t       new_flow_id

    ,input  logic           commit_val
    ,input  flow_id_t       commit_flow_id
    ,input  rx_ptr_t        commit_ptr

    ,output logic           copy_val
    ,output flow_id_t       copy_flow_id
    ,output rx_ptr_t        copy_offset
    ,output chunk_len_t     copy_len
    ,input  logic           copy_rdy
);
    logic [NUM_ENGINES-1:0] dispatch_val;
    flow_id_t               dispatch_flow_id;
    logic [NUM_ENGINES-1:0] idle;
    logic [NUM_ENGINES-1:0] requeue_val;
    flow_id_t               requeue_flow_id [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] requeue_rdy;

    ptr_access_if           ptr_if  [NUM_ENGINES] ();
    copy_req_if             copy_if [NUM_ENGINES] ();

    flow_sched #(.NUM_ENGINES(NUM_ENGINES)) i_flow_sched (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.new_flow_val      (new_flow_val       )
        ,.new_flow_id       (new_flow_id        )
        ,.dispatch_val      (dispatch_val       )
        ,.dispatch_flow_id  (dispatch_flow_id   )
        ,.idle              (idle               )
        ,.requeue_val       (requeue_val        )
        ,.requeue_flow_id   (requeue_flow_id    )
        ,.requeue_rdy       (requeue_rdy        )
    );

    flow_ptr_table #(.NUM_ENGINES(NUM_ENGINES)) i_flow_ptr_table (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.commit_val        (commit_val         )
        ,.commit_flow_id    (commit_flow_id     )
        ,.commit_ptr        (commit_ptr         )
        ,.ptr               (ptr_if             )
    );

    generate
        for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
            echo_engine i_echo_engine (
                 .clk               (clk                )
                ,.rst               (rst                )
                ,.dispatch_val      (dispatch_val[i]    )
                ,.dispatch_flow_id  (dispatch_flow_id   )
                ,.idle              (idle[i]            )
                ,.requeue_val       (requeue_val[i]     )
                ,.requeue_flow_id   (requeue_flow_id[i] )
                ,.requeue_rdy       (requeue_rdy[i]     )
                ,.ptr               (ptr_if[i]          )
                ,.copy              (copy_if[i]         )
            );
        end
    endgenerate

    copy_req_arbiter #(.NUM_ENGINES(NUM_ENGINES)) i_copy_req_arbiter (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.req               (copy_if            )
        ,.copy_val          (copy_val           )
        ,.copy_flow_id      (copy_flow_id       )
        ,.copy_offset       (copy_offset        )
        ,.copy_len          (copy_len           )
        ,.copy_rdy          (copy_rdy           )
    );

endmodule

`default_nettype wire

// ==== verification/tb_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_echo_top import echo_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk            = 1'b0;
    logic        rst            = 1'b1;
    logic        new_flow_val   = 1'b0;
    flow_id_t    new_flow_id    = '0;
    logic        commit_val     = 1'b0;
    flow_id_t    commit_flow_id = '0;
    rx_ptr_t     commit_ptr     = '0;
    logic        copy_rdy       = 1'b1;
    logic        copy_val;
    flow_id_t    copy_flow_id;
    rx_ptr_t     copy_offset;
    chunk_len_t  copy_len;

    // reference model with one entry per flow.
    rx_ptr_t     exp_off     [MAX_FLOW_CNT];
    rx_ptr_t     last_commit [MAX_FLOW_CNT];
    int          remaining   [MAX_FLOW_CNT];
    int          sum_len     [MAX_FLOW_CNT];
    int          req_cnt     [MAX_FLOW_CNT];
    logic        notified    [MAX_FLOW_CNT];

    flow_id_t    log_flow [$];
    rx_ptr_t     log_off  [$];
    chunk_len_t  log_len  [$];

    string       cur_test     = "reset";
    int          errors       = 0;
    int          tests_run    = 0;
    int          err_at_start = 0;
    int          cycles       = 0;
    logic        stall_en     = 1'b0;
    logic        rdy_level    = 1'b1;
    int          stretch      = 0;
    int          stall_cycles = 0;
    logic        stalled_q    = 1'b0;
    flow_id_t    held_flow;
    rx_ptr_t     held_off;
    chunk_len_t  held_len;
    flow_id_t    mon_f;
    int          mon_len;

    echo_top #(.NUM_ENGINES(2)) i_echo_top (
         .clk               (clk            )
        ,.rst               (rst            )
        ,.new_flow_val      (new_flow_val   )
        ,.new_flow_id       (new_flow_id    )
        ,.commit_val        (commit_val     )
        ,.commit_flow_id    (commit_flow_id )
        ,.commit_ptr        (commit_ptr     )
        ,.copy_val          (copy_val       )
        ,.copy_flow_id      (copy_flow_id   )
        ,.copy_offset       (copy_offset    )
        ,.copy_len          (copy_len       )
        ,.copy_rdy          (copy_rdy       )
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles in test %s", cycles, cur_test);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare_flow(input string name, input flow_id_t exp, input flow_id_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected flow %0d, actual flow %0d", name, exp, act);
        end
    endtask

    task automatic compare_ptr(input string name, input rx_ptr_t exp, input rx_ptr_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected pointer %0d, actual pointer %0d", name, exp, act);
        end
    endtask

    task automatic compare_len(input string name, input chunk_len_t exp, input chunk_len_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected length %0d, actual length %0d", name, exp, act);
        end
    endtask

    // random stretches of copy_rdy low while back-pressure is on.
    always @(negedge clk) begin
        if (stall_en) begin
            if (stretch == 0) begin
                rdy_level = ($urandom_range(0, 1) == 1);
                stretch   = $urandom_range(1, 6);
            end
            stretch--;
            copy_rdy = rdy_level;
        end else begin
            copy_rdy = 1'b1;
        end
    end

    // checks every transfer against the model.
    always @(posedge clk) begin
        if (!rst) begin
            if (stalled_q && !copy_val) begin
                errors++;
                $display("%s: copy_val dropped before the request was taken", cur_test);
            end else if (stalled_q) begin
                compare_flow(cur_test, held_flow, copy_flow_id);
                compare_ptr(cur_test, held_off, copy_offset);
                compare_len(cur_test, held_len, copy_len);
            end
            stalled_q = copy_val && !copy_rdy;
            held_flow = copy_flow_id;
            held_off  = copy_offset;
            held_len  = copy_len;
            if (stalled_q) begin
                stall_cycles++;
            end
            if (copy_val && copy_rdy) begin
                mon_f   = copy_flow_id;
                mon_len = (remaining[mon_f] > MAX_CHUNK) ? MAX_CHUNK : remaining[mon_f];
                if (!notified[mon_f]) begin
                    errors++;
                    $display("%s: copy request for flow %0d, never notified", cur_test, mon_f);
                end
                compare_ptr(cur_test, exp_off[mon_f], copy_offset);
                compare_len(cur_test, chunk_len_t'(mon_len), copy_len);
                exp_off[mon_f]   = exp_off[mon_f] + rx_ptr_t'(mon_len);   // wraps at 4096.
                remaining[mon_f] = remaining[mon_f] - mon_len;
                sum_len[mon_f]   = sum_len[mon_f] + int'(copy_len);
                req_cnt[mon_f]++;
                log_flow.push_back(copy_flow_id);
                log_off.push_back(copy_offset);
                log_len.push_back(copy_len);
            end
        end
    end

    function automatic logic all_drained();
        for (int f = 0; f < MAX_FLOW_CNT; f++) begin
            if (remaining[f] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic notify_flow(input flow_id_t f);
        @(negedge clk);
        new_flow_val = 1'b1;
        new_flow_id  = f;
        notified[f]  = 1'b1;
        @(negedge clk);
        new_flow_val = 1'b0;
    endtask

    task automatic set_commit(input flow_id_t f, input rx_ptr_t c);
        @(negedge clk);
        commit_val     = 1'b1;
        commit_flow_id = f;
        commit_ptr     = c;
        remaining[f]   = remaining[f] + int'(rx_ptr_t'(c - last_commit[f]));
        last_commit[f] = c;
        @(negedge clk);
        commit_val = 1'b0;
    endtask

    task automatic wait_drained();
        while (!all_drained()) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
        log_flow.delete();
        log_off.delete();
        log_len.delete();
    endtask

    task automatic end_test();
        tests_run++;
        $display("%s: %s", cur_test, (errors == err_at_start) ? "ok" : "mismatches found");
    endtask

    task automatic test_idle_after_reset();
        start_test("idle_after_reset");
        repeat (50) begin
            @(negedge clk);
            if (copy_val !== 1'b0) begin
                errors++;
                $display("%s: copy_val went high with no flow notified", cur_test);
            end
        end
        end_test();
    endtask

    task automatic test_single_flow();
        start_test("single_flow");
        set_commit(4'd1, 12'd40);
        notify_flow(4'd1);
        wait_drained();
        repeat (100) @(negedge clk);
        if (log_off.size() != 1 || req_cnt[1] != 1) begin
            errors++;
            $display("FAILED %s: expected 1 request, actual %0d", cur_test, req_cnt[1]);
        end else begin
            compare_flow(cur_test, 4'd1, log_flow[0]);
            compare_ptr(cur_test, 12'd0, log_off[0]);
            compare_len(cur_test, 7'd40, log_len[0]);
        end
        end_test();
    endtask

    task automatic test_chunking_and_wrap();
        start_test("chunking_and_wrap");
        set_commit(4'd2, 12'd150);
        notify_flow(4'd2);
        wait_drained();
        if (log_off.size() != 3) begin
            errors++;
            $display("FAILED %s: expected 3 requests, actual %0d", cur_test, log_off.size());
        end else begin
            for (int i = 0; i < 3; i++) begin
                compare_ptr(cur_test, rx_ptr_t'(i * 64), log_off[i]);
                compare_len(cur_test, (i < 2) ? 7'd64 : 7'd22, log_len[i]);
            end
        end
        set_commit(4'd2, rx_ptr_t'(4100));   // lands at 4 after the wrap.
        wait_drained();
        if (req_cnt[2] != 65) begin
            errors++;
            $display("FAILED %s: expected 65 requests, actual %0d", cur_test, req_cnt[2]);
        end
        compare_ptr(cur_test, 12'd4, log_off[$] + rx_ptr_t'(log_len[$]));
        end_test();
    endtask

    task automatic run_three_flows(input flow_id_t base, input int c0, input int c1, input int c2);
        int       commits [3];
        flow_id_t f;
        commits[0] = c0;
        commits[1] = c1;
        commits[2] = c2;
        for (int i = 0; i < 3; i++) begin
            set_commit(base + flow_id_t'(i), rx_ptr_t'(commits[i]));
        end
        for (int i = 0; i < 3; i++) begin
            notify_flow(base + flow_id_t'(i));
        end
        wait_drained();
        for (int i = 0; i < 3; i++) begin
            f = base + flow_id_t'(i);
            compare_ptr(cur_test, rx_ptr_t'(commits[i]), rx_ptr_t'(sum_len[f]));
        end
    endtask

    task automatic test_concurrent_flows();
        start_test("concurrent_flows");
        run_three_flows(4'd3, 100, 300, 37);
        end_test();
    endtask

    task automatic test_copy_backpressure();
        start_test("copy_backpressure");
        stall_cycles = 0;
        stall_en     = 1'b1;
        run_three_flows(4'd6, 200, 90, 333);
        stall_en = 1'b0;
        if (stall_cycles == 0) begin
            errors++;
            $display("%s: copy_rdy never held back a pending request", cur_test);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(54));
        for (int f = 0; f < MAX_FLOW_CNT; f++) begin
            exp_off[f]     = '0;
            last_commit[f] = '0;
            remaining[f]   = 0;
            sum_len[f]     = 0;
            req_cnt[f]     = 0;
            notified[f]    = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_idle_after_reset();
        test_single_flow();
        test_chunking_and_wrap();
        test_concurrent_flows();
        test_copy_backpressure();

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/echo_pkg.sv
rtl/echo_ifs.sv
rtl/flow_sched.sv
rtl/flow_ptr_table.sv
rtl/echo_engine.sv
rtl/copy_req_arbiter.sv
rtl/echo_top.sv
verification/tb_echo_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the echo core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_echo_top -f src.f -o tb_echo_top \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_echo_top > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
